/* src/sonar_pkg.sv */
`default_nettype none

package sonar_pkg;

    localparam int BUS_W  = 32;
    localparam int DATA_W = 16;

    typedef logic signed [DATA_W-1:0] sample_t;
    typedef logic [BUS_W-1:0]         bus_word_t;

    // Address map
    localparam logic [3:0] WIN_NIBBLE = 4'd3;  // Upper address nibble of this slave
    localparam int BLOCK_WORDS = 16;           // Words per block

    // Global block, block 0
    localparam int REG_STATUS    = 0;
    localparam int REG_PRESCALER = 1;

    // Channel block, block k+1 for channel k
    localparam int REG_THRESHOLD = 0;
    localparam int REG_SAMPLE    = 1;  // Read only

    localparam int PRESCALER_RESET = 49;
    localparam int SAMPLE_MAX      = 32767;  // Ones count saturates here

endpackage

`default_nettype wire

/* src/mic_clock_gen.sv */
`default_nettype none

module mic_clock_gen #(
    parameter int MIC_DIV = 5
) (
    input  logic wb_clk_i,
    input  logic wb_rst_i,
    output logic mclk_o,
    output logic ce_pdm_o
);

    localparam int CNT_W = (MIC_DIV > 1) ? $clog2(MIC_DIV) : 1;

    logic [CNT_W-1:0] half_cnt;
    logic             half_done;

    assign half_done = half_cnt == CNT_W'(MIC_DIV - 1);

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            half_cnt <= '0;
            mclk_o   <= 1'b0;
            ce_pdm_o <= 1'b0;
        end else begin
            ce_pdm_o <= half_done && !mclk_o;  // High in the cycle mclk goes high
            if (half_done) begin
                half_cnt <= '0;
                mclk_o   <= !mclk_o;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // Microphones drive data for the rising edge
    a_pdm_on_high: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        ce_pdm_o |-> mclk_o);

endmodule

`default_nettype wire

/* src/pcm_rate_gen.sv */
`default_nettype none

module pcm_rate_gen
    import sonar_pkg::*;
(
    input  logic    wb_clk_i,
    input  logic    wb_rst_i,
    input  logic    ce_pdm_i,
    input  sample_t prescaler_i,
    output logic    ce_pcm_o
);

    logic [DATA_W-1:0] win_cnt;
    logic [DATA_W-1:0] prescaler_q;
    logic              restart;
    logic              win_end;

    assign restart  = prescaler_i != prescaler_q;  // New prescaler starts a fresh window
    assign win_end  = win_cnt == prescaler_i;
    assign ce_pcm_o = ce_pdm_i && win_end && !restart;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            win_cnt     <= '0;
            prescaler_q <= DATA_W'(PRESCALER_RESET);
        end else begin
            prescaler_q <= prescaler_i;
            if (restart)
                win_cnt <= '0;
            else if (ce_pdm_i)
                win_cnt <= win_end ? '0 : win_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/sonar_channel.sv */
`default_nettype none

module sonar_channel
    import sonar_pkg::*;
(
    input  logic       wb_clk_i,
    input  logic       wb_rst_i,
    input  logic       sel_i,
    input  logic       reg_wr_i,
    input  logic [3:0] reg_off_i,
    input  sample_t    wdata_i,
    input  logic       ce_pdm_i,
    input  logic       ce_pcm_i,
    input  logic       mclear_i,
    input  logic       pdm_i,
    output logic       ack_o,
    output sample_t    rdata_o,
    output logic       det_o
);

    sample_t acc;
    sample_t acc_next;
    sample_t sample;
    sample_t threshold;
    logic    access;
    logic    hit;

    // Count includes the bit sampled this cycle
    always_comb begin
        acc_next = acc;
        if (ce_pdm_i && pdm_i && acc != sample_t'(SAMPLE_MAX))
            acc_next = acc + 16'sd1;
    end

    assign hit    = acc_next > threshold;  // Signed compare
    assign access = sel_i && !ack_o;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            acc    <= '0;
            sample <= '0;
        end else if (mclear_i) begin
            acc <= '0;
        end else if (ce_pcm_i) begin
            sample <= acc_next;
            acc    <= '0;  // Next window starts empty
        end else begin
            acc <= acc_next;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i)
            det_o <= 1'b0;
        else if (mclear_i)
            det_o <= 1'b0;  // Clear wins over set
        else if (ce_pcm_i && hit)
            det_o <= 1'b1;
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            ack_o     <= 1'b0;
            threshold <= '0;
        end else begin
            ack_o <= access;
            if (access && reg_wr_i && reg_off_i == 4'(REG_THRESHOLD))
                threshold <= wdata_i;  // Sample register ignores writes
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (sel_i) begin
            case (reg_off_i)
                4'(REG_THRESHOLD): rdata_o <= threshold;
                4'(REG_SAMPLE):    rdata_o <= sample;
                default:           rdata_o <= '0;
            endcase
        end
    end

    // An ack answers the select from the decoder in the previous cycle
    a_ack_after_sel: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        ack_o |-> $past(sel_i));

endmodule

`default_nettype wire

/* src/sonar_ctrl_regs.sv */
`default_nettype none

module sonar_ctrl_regs
    import sonar_pkg::*;
#(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                    wb_clk_i,
    input  logic                    wb_rst_i,
    input  logic                    glob_sel_i,
    input  logic                    reg_wr_i,
    input  logic [3:0]              reg_off_i,
    input  bus_word_t               wbs_dat_i,
    input  logic [NUM_CHANNELS-1:0] det_i,
    output logic                    glob_ack_o,
    output bus_word_t               glob_rdata_o,
    output sample_t                 prescaler_o,
    output logic                    irq_o
);

    logic [NUM_CHANNELS-1:0] status;
    logic                    access;

    assign access = glob_sel_i && !glob_ack_o;  // Held request is ignored during its ack

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            glob_ack_o  <= 1'b0;
            prescaler_o <= sample_t'(PRESCALER_RESET);
            status      <= '0;
        end else begin
            glob_ack_o <= access;
            status     <= det_i;  // Snapshot of the sticky channel flags
            if (access && reg_wr_i && reg_off_i == 4'(REG_PRESCALER))
                prescaler_o <= wbs_dat_i[DATA_W-1:0];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (glob_sel_i) begin
            case (reg_off_i)
                4'(REG_STATUS):    glob_rdata_o <= bus_word_t'(status);
                4'(REG_PRESCALER): glob_rdata_o <= {{(BUS_W - DATA_W){1'b0}}, prescaler_o};
                default:           glob_rdata_o <= '0;
            endcase
        end
    end

    assign irq_o = |status;

    a_num_channels: assert property (@(posedge wb_clk_i) NUM_CHANNELS inside {[1:32]});

    // Every request yields a single-cycle ack, never back to back
    a_ack_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        glob_ack_o |=> !glob_ack_o);

endmodule

`default_nettype wire

/* src/wb_channel_decode.sv */
`default_nettype none

module wb_channel_decode
    import sonar_pkg::*;
#(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                    wb_clk_i,
    input  logic                    wbs_cyc_i,
    input  logic                    wbs_stb_i,
    input  logic                    wbs_we_i,
    input  logic [3:0]              wbs_sel_i,
    input  bus_word_t               wbs_adr_i,
    input  bus_word_t               wbs_dat_i,
    input  logic [NUM_CHANNELS-1:0] chan_ack_i,
    input  sample_t                 chan_rdata_i [NUM_CHANNELS],
    input  logic                    glob_ack_i,
    input  bus_word_t               glob_rdata_i,
    output logic [NUM_CHANNELS-1:0] chan_sel_o,
    output logic                    glob_sel_o,
    output logic                    reg_wr_o,
    output logic [3:0]              reg_off_o,
    output sample_t                 wdata_o,
    output logic                    wbs_ack_o,
    output bus_word_t               wbs_dat_o
);

    localparam int OFF_W = $clog2(BLOCK_WORDS);
    localparam int BLK_W = 10 - OFF_W;

    logic             req;
    logic [9:0]       word_addr;
    logic [BLK_W-1:0] block;
    logic [OFF_W-1:0] offset;
    logic             unmapped;

    assign req       = wbs_cyc_i && wbs_stb_i && (wbs_adr_i[31:28] == WIN_NIBBLE);
    assign word_addr = wbs_adr_i[11:2];
    assign block     = word_addr[9:OFF_W];
    assign offset    = word_addr[OFF_W-1:0];
    assign unmapped  = block > BLK_W'(NUM_CHANNELS);

    always_comb begin
        chan_sel_o = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (req && block == BLK_W'(i + 1))
                chan_sel_o[i] = 1'b1;
        end
    end

    assign glob_sel_o = req && !(|chan_sel_o);  // Global block and anything unmapped
    // Unmapped blocks land on an unused global word, so they read zero and write nothing
    assign reg_off_o  = unmapped ? 4'(BLOCK_WORDS - 1) : offset;
    assign reg_wr_o   = wbs_we_i && wbs_sel_i[0] && !unmapped;
    assign wdata_o    = wbs_dat_i[DATA_W-1:0];

    assign wbs_ack_o = glob_ack_i || (|chan_ack_i);

    always_comb begin
        wbs_dat_o = glob_ack_i ? glob_rdata_i : '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (chan_ack_i[i])
                wbs_dat_o = {{(BUS_W - DATA_W){chan_rdata_i[i][DATA_W-1]}}, chan_rdata_i[i]};
        end
    end

    // Responders are selected one at a time, so their acks never overlap
    a_ack_onehot: assert property (@(posedge wb_clk_i) $onehot0({glob_ack_i, chan_ack_i}));

endmodule

`default_nettype wire

/* src/sonar_array_top.sv */
`default_nettype none

module sonar_array_top
    import sonar_pkg::*;
#(
    parameter int NUM_CHANNELS = 4,
    parameter int MIC_DIV      = 5
) (
    input  logic                    wb_clk_i,
    input  logic                    wb_rst_i,
    input  logic                    wbs_cyc_i,
    input  logic                    wbs_stb_i,
    input  logic                    wbs_we_i,
    input  logic [3:0]              wbs_sel_i,
    input  bus_word_t               wbs_adr_i,
    input  bus_word_t               wbs_dat_i,
    input  logic                    mclear_i,
    input  logic [NUM_CHANNELS-1:0] pdm_i,
    output logic                    wbs_ack_o,
    output bus_word_t               wbs_dat_o,
    output logic                    mclk_o,
    output logic                    irq_o
);

    logic [NUM_CHANNELS-1:0] chan_sel;
    logic                    glob_sel;
    logic                    reg_wr;
    logic [3:0]              reg_off;
    sample_t                 wdata;

    logic [NUM_CHANNELS-1:0] chan_ack;
    sample_t                 chan_rdata [NUM_CHANNELS];
    logic                    glob_ack;
    bus_word_t               glob_rdata;

    logic                    ce_pdm;
    logic                    ce_pcm;
    sample_t                 prescaler;
    logic [NUM_CHANNELS-1:0] det;

    wb_channel_decode #(
        .NUM_CHANNELS(NUM_CHANNELS)
    ) decode0 (
        .wb_clk_i    (wb_clk_i),
        .wbs_cyc_i   (wbs_cyc_i),
        .wbs_stb_i   (wbs_stb_i),
        .wbs_we_i    (wbs_we_i),
        .wbs_sel_i   (wbs_sel_i),
        .wbs_adr_i   (wbs_adr_i),
        .wbs_dat_i   (wbs_dat_i),
        .chan_ack_i  (chan_ack),
        .chan_rdata_i(chan_rdata),
        .glob_ack_i  (glob_ack),
        .glob_rdata_i(glob_rdata),
        .chan_sel_o  (chan_sel),
        .glob_sel_o  (glob_sel),
        .reg_wr_o    (reg_wr),
        .reg_off_o   (reg_off),
        .wdata_o     (wdata),
        .wbs_ack_o   (wbs_ack_o),
        .wbs_dat_o   (wbs_dat_o)
    );

    sonar_ctrl_regs #(
        .NUM_CHANNELS(NUM_CHANNELS)
    ) ctrl0 (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .glob_sel_i  (glob_sel),
        .reg_wr_i    (reg_wr),
        .reg_off_i   (reg_off),
        .wbs_dat_i   (wbs_dat_i),
        .det_i       (det),
        .glob_ack_o  (glob_ack),
        .glob_rdata_o(glob_rdata),
        .prescaler_o (prescaler),
        .irq_o       (irq_o)
    );

    mic_clock_gen #(
        .MIC_DIV(MIC_DIV)
    ) mic0 (
        .wb_clk_i(wb_clk_i),
        .wb_rst_i(wb_rst_i),
        .mclk_o  (mclk_o),
        .ce_pdm_o(ce_pdm)
    );

    pcm_rate_gen pcm0 (
        .wb_clk_i   (wb_clk_i),
        .wb_rst_i   (wb_rst_i),
        .ce_pdm_i   (ce_pdm),
        .prescaler_i(prescaler),
        .ce_pcm_o   (ce_pcm)
    );

    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
        sonar_channel chan (
            .wb_clk_i (wb_clk_i),
            .wb_rst_i (wb_rst_i),
            .sel_i    (chan_sel[i]),
            .reg_wr_i (reg_wr),
            .reg_off_i(reg_off),
            .wdata_i  (wdata),
            .ce_pdm_i (ce_pdm),
            .ce_pcm_i (ce_pcm),
            .mclear_i (mclear_i),
            .pdm_i    (pdm_i[i]),
            .ack_o    (chan_ack[i]),
            .rdata_o  (chan_rdata[i]),
            .det_o    (det[i])
        );
    end

endmodule

`default_nettype wire

/* verification/tb_sonar_array.sv */
`default_nettype none

module tb_sonar_array
    import sonar_pkg::*;
();

    localparam int NUM_CHANNELS    = 4;
    localparam int MIC_DIV         = 2;
    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DLY       = 10;
    localparam int RESET_CYCLES    = 5;
    localparam int STRAY_CYCLES    = 20;
    localparam int PRESC_MAX       = 9;
    localparam int PLANNED_WINDOWS = 3;
    localparam int MARGIN_CYCLES   = 600;
    localparam int WATCHDOG_TIME   =
        (PLANNED_WINDOWS * (PRESC_MAX + 1) * 2 * MIC_DIV + MARGIN_CYCLES) * CLK_PERIOD;
    localparam logic [31:0] SEED   = 32'heddc_5438;
    localparam int SMALL_THR       = 3;    // Thresholds below this sit under every window count
    localparam int LONG_THR        = 100;  // Above even the first window after a restart

    logic                    wb_clk_i = 1'b0;
    logic                    wb_rst_i;
    logic                    wbs_cyc_i;
    logic                    wbs_stb_i;
    logic                    wbs_we_i;
    logic [3:0]              wbs_sel_i;
    bus_word_t               wbs_adr_i;
    bus_word_t               wbs_dat_i;
    logic                    mclear_i;
    logic [NUM_CHANNELS-1:0] pdm_i;
    logic                    wbs_ack_o;
    bus_word_t               wbs_dat_o;
    logic                    mclk_o;
    logic                    irq_o;

    int        errors = 0;
    logic      chk_dat = 1'b0;  // Read data is compared on the next ack
    bus_word_t exp_dat = '0;
    logic      bus_req;
    logic      mclk_last = 1'b0;
    logic      mclk_seen = 1'b0;
    int        mclk_run = 0;     // Cycles the current mclk level has lasted

    sonar_array_top #(
        .NUM_CHANNELS(NUM_CHANNELS),
        .MIC_DIV     (MIC_DIV)
    ) dut0 (
        .wb_clk_i (wb_clk_i),
        .wb_rst_i (wb_rst_i),
        .wbs_cyc_i(wbs_cyc_i),
        .wbs_stb_i(wbs_stb_i),
        .wbs_we_i (wbs_we_i),
        .wbs_sel_i(wbs_sel_i),
        .wbs_adr_i(wbs_adr_i),
        .wbs_dat_i(wbs_dat_i),
        .mclear_i (mclear_i),
        .pdm_i    (pdm_i),
        .wbs_ack_o(wbs_ack_o),
        .wbs_dat_o(wbs_dat_o),
        .mclk_o   (mclk_o),
        .irq_o    (irq_o)
    );

    always #(CLK_PERIOD / 2) wb_clk_i = !wb_clk_i;

    assign bus_req = wbs_cyc_i && wbs_stb_i && (wbs_adr_i[31:28] == WIN_NIBBLE);

    always @(posedge wb_clk_i) begin
        mclk_last <= mclk_o;
        if (wb_rst_i) begin
            mclk_run  <= 0;
            mclk_seen <= 1'b0;
        end else if (mclk_o != mclk_last) begin
            mclk_run  <= 1;
            mclk_seen <= 1'b1;  // Level right after reset is not a full half period
        end else begin
            mclk_run <= mclk_run + 1;
        end
    end

    a_rdata: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        (wbs_ack_o && chk_dat) |-> wbs_dat_o == exp_dat)
    else begin
        errors++;
        $display("Mismatch at %0t: wbs_dat_o expected %h, got %h", $time,
                 $sampled(exp_dat), $sampled(wbs_dat_o));
    end

    a_ack_follows_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        $rose(bus_req) |=> wbs_ack_o)
    else begin
        errors++;
        $display("No acknowledge one cycle after a request at %0t", $time);
    end

    a_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wbs_ack_o |=> !wbs_ack_o)
    else begin
        errors++;
        $display("wbs_ack_o stayed high for two cycles at %0t", $time);
    end

    a_no_stray_ack: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        !bus_req |=> !wbs_ack_o)
    else begin
        errors++;
        $display("Acknowledge without a request in the window at %0t", $time);
    end

    a_mclk_half: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        (mclk_o != mclk_last && mclk_seen) |-> mclk_run == MIC_DIV)
    else begin
        errors++;
        $display("Mismatch at %0t: mclk_o level length expected %0d, got %0d", $time,
                 MIC_DIV, $sampled(mclk_run));
    end

    function automatic bus_word_t reg_addr(input int block, input int offset);
        return {WIN_NIBBLE, 16'h0000, 12'(((block * BLOCK_WORDS) + offset) * 4)};
    endfunction

    function automatic bus_word_t sext16(input sample_t value);
        return {{16{value[15]}}, value};
    endfunction

    task automatic check_bit(input string name, input logic act, input logic exp);
        assert (act === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // Holds the request until the ack, then releases the bus
    task automatic bus_cycle(input logic we, input logic [3:0] sel, input bus_word_t adr,
                             input bus_word_t wdat, input logic chk, input bus_word_t exp);
        @(posedge wb_clk_i);
        #DRIVE_DLY;
        chk_dat   = chk;
        exp_dat   = exp;
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wbs_we_i  = we;
        wbs_sel_i = sel;
        wbs_adr_i = adr;
        wbs_dat_i = wdat;
        do begin
            @(posedge wb_clk_i);
            #DRIVE_DLY;
        end while (!wbs_ack_o);
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
    endtask

    task automatic read_check(input bus_word_t adr, input bus_word_t exp);
        bus_cycle(1'b0, 4'hf, adr, '0, 1'b1, exp);
    endtask

    task automatic write_reg(input bus_word_t adr, input bus_word_t dat, input logic [3:0] sel);
        bus_cycle(1'b1, sel, adr, dat, 1'b0, '0);
    endtask

    task automatic stray_access(input bus_word_t adr);
        @(posedge wb_clk_i);
        #DRIVE_DLY;
        chk_dat   = 1'b0;
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wbs_we_i  = 1'b0;
        wbs_sel_i = 4'hf;
        wbs_adr_i = adr;
        repeat (STRAY_CYCLES) begin
            @(posedge wb_clk_i);
            #DRIVE_DLY;
            assert (!wbs_ack_o) else begin
                errors++;
                $display("Acknowledge for an address outside the window at %0t", $time);
            end
        end
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
    endtask

    initial begin
        int                      presc;
        int                      presc_next;
        bus_word_t               stray_adr;
        sample_t                 thr_exp [NUM_CHANNELS];
        sample_t                 cnt_exp;
        logic [NUM_CHANNELS-1:0] pdm_level;
        logic [NUM_CHANNELS-1:0] det_exp;

        void'($urandom(SEED));
        wb_rst_i  = 1'b1;
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
        wbs_sel_i = '0;
        wbs_adr_i = '0;
        wbs_dat_i = '0;
        mclear_i  = 1'b0;
        pdm_i     = '0;
        repeat (RESET_CYCLES) @(posedge wb_clk_i);
        #DRIVE_DLY;
        wb_rst_i = 1'b0;

        // Reset state
        check_bit("mclk_o", mclk_o, 1'b0);
        check_bit("irq_o", irq_o, 1'b0);
        read_check(reg_addr(0, REG_PRESCALER), bus_word_t'(PRESCALER_RESET));
        read_check(reg_addr(0, REG_STATUS), '0);
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            read_check(reg_addr(i + 1, REG_THRESHOLD), '0);
            read_check(reg_addr(i + 1, REG_SAMPLE), '0);
        end

        // Register access
        presc = 2 + int'($urandom % 6);
        write_reg(reg_addr(0, REG_PRESCALER), bus_word_t'(presc), 4'h1);
        read_check(reg_addr(0, REG_PRESCALER), bus_word_t'(presc));
        write_reg(reg_addr(0, REG_PRESCALER), bus_word_t'(presc + 5), 4'he);
        read_check(reg_addr(0, REG_PRESCALER), bus_word_t'(presc));
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            thr_exp[i] = sample_t'($urandom % SMALL_THR);
            if (i == 1)
                thr_exp[i][15] = 1'b1;  // One negative threshold
            else if (i == 2)
                thr_exp[i] = sample_t'(LONG_THR + int'($urandom % 1000));
            write_reg(reg_addr(i + 1, REG_THRESHOLD), sext16(thr_exp[i]), 4'h3);
            read_check(reg_addr(i + 1, REG_THRESHOLD), sext16(thr_exp[i]));
        end
        // Non-negative again so an idle input stays clear after mclear
        thr_exp[1] = sample_t'($urandom % SMALL_THR);
        write_reg(reg_addr(2, REG_THRESHOLD), sext16(thr_exp[1]), 4'h1);
        read_check(reg_addr(2, REG_THRESHOLD), sext16(thr_exp[1]));
        write_reg(reg_addr(1, REG_THRESHOLD), 32'h0000_0123, 4'h2);
        read_check(reg_addr(1, REG_THRESHOLD), sext16(thr_exp[0]));
        write_reg(reg_addr(1, REG_SAMPLE), 32'h0000_1234, 4'hf);
        read_check(reg_addr(1, REG_SAMPLE), '0);
        read_check(reg_addr(NUM_CHANNELS + 1, 0), '0);
        write_reg(reg_addr(NUM_CHANNELS + 1, REG_PRESCALER), 32'h0000_0077, 4'hf);
        read_check(reg_addr(0, REG_PRESCALER), bus_word_t'(presc));
        stray_adr = reg_addr(0, REG_PRESCALER);
        stray_adr[31:28] = 4'h4;
        stray_access(stray_adr);

        // Decimation over two full windows after the restart
        pdm_level = 4'b0111;
        @(posedge wb_clk_i);
        #DRIVE_DLY;
        pdm_i = pdm_level;
        presc_next = presc + 1 + int'($urandom % 2);
        write_reg(reg_addr(0, REG_PRESCALER), bus_word_t'(presc_next), 4'h1);
        read_check(reg_addr(0, REG_PRESCALER), bus_word_t'(presc_next));
        repeat (PLANNED_WINDOWS * (presc_next + 1) * 2 * MIC_DIV) @(posedge wb_clk_i);
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            cnt_exp = pdm_level[i] ? sample_t'(presc_next + 1) : '0;
            det_exp[i] = cnt_exp > thr_exp[i];
            read_check(reg_addr(i + 1, REG_SAMPLE), sext16(cnt_exp));
        end

        // Detection and clear
        read_check(reg_addr(0, REG_STATUS), bus_word_t'(det_exp));
        check_bit("irq_o", irq_o, |det_exp);
        @(posedge wb_clk_i);
        #DRIVE_DLY;
        pdm_i    = '0;
        mclear_i = 1'b1;
        repeat (3) @(posedge wb_clk_i);
        #DRIVE_DLY;
        mclear_i = 1'b0;
        read_check(reg_addr(0, REG_STATUS), '0);
        check_bit("irq_o", irq_o, 1'b0);

        repeat (2) @(posedge wb_clk_i);
        $display("Run complete with %0d errors", errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        errors++;
        $display("Watchdog expired at %0t before the test sequence completed", $time);
        $display("Run stopped with %0d errors", errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
src/sonar_pkg.sv
src/mic_clock_gen.sv
src/pcm_rate_gen.sv
src/sonar_channel.sv
src/sonar_ctrl_regs.sv
src/wb_channel_decode.sv
src/sonar_array_top.sv
verification/tb_sonar_array.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_sonar_array
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert -j 0 --top-module $(TOP)
PASS_MSG   := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
